// File: verilog/isaPkg.sv
package isaPkg;

	// data and instruction word
	typedef logic [15:0] word_t;
	typedef logic [3:0] regAddr_t;
	typedef logic [9:0] memAddr_t;
	// offset inside the I/O window
	typedef logic [3:0] portAddr_t;
	typedef logic [7:0] imm_t;

	typedef enum logic [3:0] {
		ADD,
		ADDI,
		SUB,
		SUBI,
		AND,
		OR,
		XOR,
		MOV,
		MOVI,
		LSHI,
		CMP,
		LOAD,
		STOR,
		BEQ,
		BLT,
		HALT
	} opcode_t;

	// instruction fields
	localparam int OPC_HI = 15;
	localparam int OPC_LO = 12;
	localparam int RDEST_HI = 11;
	localparam int RDEST_LO = 8;
	localparam int RSRC_HI = 7;
	localparam int RSRC_LO = 4;
	localparam int IMM_HI = 7;
	localparam int IMM_LO = 0;

	// stores from here up to the top of RAM go to the output port
	localparam memAddr_t IO_BASE = 10'h3F0;
	localparam int RAM_WORDS = 1024;

endpackage

// File: verilog/cpuCtrlPkg.sv
package cpuCtrlPkg;

	import isaPkg::*;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DECODE,
		EXEC,
		MEMRD,
		MEMWAIT,
		PORTWAIT,
		HALTED
	} cpuState_t;

	// writeback source
	typedef logic [1:0] loadSel_t;
	localparam loadSel_t SEL_ALU = 2'd0;
	localparam loadSel_t SEL_RAM = 2'd1;
	localparam loadSel_t SEL_IMM = 2'd2;

	// next pc source
	typedef logic [1:0] pcSel_t;
	localparam pcSel_t PC_INC = 2'd0;
	localparam pcSel_t PC_DISP = 2'd1;
	localparam pcSel_t PC_REG = 2'd2;

	typedef logic [4:0] flags_t;
	localparam int FLAG_C = 4;
	localparam int FLAG_L = 3;
	localparam int FLAG_F = 2;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 0;

	// the ALU is steered straight by the opcode
	typedef opcode_t aluOp_t;

endpackage

// File: verilog/programLoader.sv
module programLoader
	import isaPkg::*;
(
	input logic Clk,
	input logic arstN,
	input logic inValid,
	output logic inReady,
	input word_t inData,
	input logic inLast,
	output logic loadWe,
	output memAddr_t loadAddr,
	output word_t loadData,
	output logic start
);

	logic accept;

	assign accept = inValid && inReady;

	// each accepted word is written on the same edge
	assign loadWe = accept;
	assign loadData = inData;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			inReady <= 1'b1;
			loadAddr <= '0;
			start <= 1'b0;
		end else begin
			start <= accept && inLast;
			if (accept) begin
				loadAddr <= loadAddr + 1'b1;
				// input stays closed once the program is in
				if (inLast) begin
					inReady <= 1'b0;
				end
			end
		end
	end

endmodule

// File: verilog/cpuRam.sv
module cpuRam
	import isaPkg::*;
(
	input logic Clk,
	input memAddr_t coreAddr,
	input word_t coreData,
	input logic coreWe,
	output word_t coreQ,
	input logic loadWe,
	input memAddr_t loadAddr,
	input word_t loadData
);

	word_t mem [RAM_WORDS];

	always_ff @(posedge Clk) begin
		// loader only writes while the core sits in IDLE
		if (loadWe) begin
			mem[loadAddr] <= loadData;
		end else if (coreWe) begin
			mem[coreAddr] <= coreData;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge Clk) begin
		coreQ <= mem[coreAddr];
	end

endmodule

// File: verilog/regFile.sv
module regFile
	import isaPkg::*;
(
	input logic Clk,
	input logic arstN,
	input logic en,
	input regAddr_t rdestLoc,
	input regAddr_t rsrcLoc,
	input word_t load,
	output word_t rdestOut,
	output word_t rsrcOut
);

	word_t regs [16];

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (en) begin
			regs[rdestLoc] <= load;
		end
	end

	assign rdestOut = regs[rdestLoc];
	assign rsrcOut = regs[rsrcLoc];

endmodule

// File: verilog/execUnit.sv
module execUnit
	import isaPkg::*;
	import cpuCtrlPkg::*;
(
	input logic Clk,
	input logic arstN,
	input imm_t imm,
	input logic signedImm,
	input logic immSel,
	input aluOp_t aluOp,
	input word_t rdestOut,
	input word_t rsrcOut,
	input word_t ramQ,
	input loadSel_t loadSel,
	input logic flagsEn,
	output word_t load,
	output flags_t flags,
	output word_t extImm
);

	word_t srcOp;
	word_t srcEff;
	word_t aluOut;
	logic [16:0] sum;
	logic isSub;
	logic ovf;
	flags_t nextFlags;

	assign extImm = signedImm ? {{8{imm[7]}}, imm} : {8'h00, imm};
	assign srcOp = immSel ? extImm : rsrcOut;

	// subtract as add of the inverted operand plus one
	assign isSub = (aluOp == SUB) || (aluOp == SUBI) || (aluOp == CMP);
	assign srcEff = isSub ? ~srcOp : srcOp;
	assign sum = {1'b0, rdestOut} + {1'b0, srcEff} + {16'd0, isSub};
	assign ovf = (rdestOut[15] == srcEff[15]) && (sum[15] != rdestOut[15]);

	always_comb begin
		case (aluOp)
			ADD, ADDI, SUB, SUBI, CMP: aluOut = sum[15:0];
			AND: aluOut = rdestOut & srcOp;
			OR: aluOut = rdestOut | srcOp;
			XOR: aluOut = rdestOut ^ srcOp;
			MOV: aluOut = srcOp;
			LSHI: aluOut = rdestOut << srcOp[3:0];
			default: aluOut = '0;
		endcase
	end

	always_comb begin
		nextFlags[FLAG_C] = sum[16];
		nextFlags[FLAG_L] = rdestOut < srcOp;
		nextFlags[FLAG_F] = ovf;
		nextFlags[FLAG_Z] = sum[15:0] == '0;
		// true sign, so after CMP this is a signed less-than
		nextFlags[FLAG_N] = sum[15] ^ ovf;
	end

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
		end else if (flagsEn) begin
			flags <= nextFlags;
		end
	end

	always_comb begin
		case (loadSel)
			SEL_ALU: load = aluOut;
			SEL_RAM: load = ramQ;
			SEL_IMM: load = extImm;
			default: load = '0;
		endcase
	end

endmodule

// File: verilog/programCounter.sv
module programCounter
	import isaPkg::*;
	import cpuCtrlPkg::*;
(
	input logic Clk,
	input logic arstN,
	input logic pcEn,
	input pcSel_t pcSel,
	input logic ramAddrSel,
	input word_t extImm,
	input word_t rsrcOut,
	output word_t pc,
	output memAddr_t coreAddr
);

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (pcEn) begin
			case (pcSel)
				PC_INC: pc <= pc + 1'b1;
				// pc already points past the branch here
				PC_DISP: pc <= pc + extImm;
				PC_REG: pc <= rsrcOut;
				default: pc <= pc;
			endcase
		end
	end

	// RAM core port address, register for LOAD/STOR
	assign coreAddr = ramAddrSel ? memAddr_t'(rsrcOut) : memAddr_t'(pc);

endmodule

// File: verilog/controlFsm.sv
module controlFsm
	import isaPkg::*;
	import cpuCtrlPkg::*;
(
	input logic Clk,
	input logic arstN,
	input logic start,
	input word_t instr,
	input flags_t flags,
	input logic portBusy,
	input memAddr_t storeAddr,
	output logic regEn,
	output logic ramEn,
	output logic pcEn,
	output logic immSel,
	output logic signedImm,
	output logic ramAddrSel,
	output loadSel_t loadSel,
	output pcSel_t pcSel,
	output aluOp_t aluOp,
	output regAddr_t rdestLoc,
	output regAddr_t rsrcLoc,
	output imm_t imm,
	output logic flagsEn,
	output logic portLoad,
	output logic halted
);

	cpuState_t state;
	cpuState_t nextState;
	word_t instrReg;
	opcode_t opcode;
	opcode_t fetchedOp;
	logic ioStore;

	assign fetchedOp = opcode_t'(instr[OPC_HI:OPC_LO]);
	assign opcode = opcode_t'(instrReg[OPC_HI:OPC_LO]);
	assign rdestLoc = instrReg[RDEST_HI:RDEST_LO];
	assign rsrcLoc = instrReg[RSRC_HI:RSRC_LO];
	assign imm = instrReg[IMM_HI:IMM_LO];
	assign aluOp = opcode;

	// only the top sixteen words of RAM can be at or above the window base
	assign ioStore = storeAddr >= IO_BASE;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
			instrReg <= '0;
			halted <= 1'b0;
		end else begin
			state <= nextState;
			halted <= state == HALTED;
			// RAM data for the fetch shows up in DECODE
			if (state == DECODE) begin
				instrReg <= instr;
			end
		end
	end

	always_comb begin
		nextState = state;
		regEn = 1'b0;
		ramEn = 1'b0;
		pcEn = 1'b0;
		immSel = 1'b0;
		signedImm = 1'b0;
		ramAddrSel = 1'b0;
		loadSel = SEL_ALU;
		pcSel = PC_INC;
		flagsEn = 1'b0;
		portLoad = 1'b0;
		case (state)
			IDLE: begin
				if (start) begin
					nextState = FETCH;
				end
			end
			FETCH: begin
				pcEn = 1'b1;
				nextState = DECODE;
			end
			DECODE: begin
				nextState = (fetchedOp == LOAD) ? MEMRD : EXEC;
			end
			EXEC: begin
				nextState = FETCH;
				case (opcode)
					ADD, SUB: begin
						regEn = 1'b1;
						flagsEn = 1'b1;
					end
					AND, OR, XOR, MOV: regEn = 1'b1;
					ADDI, SUBI: begin
						regEn = 1'b1;
						immSel = 1'b1;
						signedImm = 1'b1;
					end
					LSHI: begin
						regEn = 1'b1;
						immSel = 1'b1;
					end
					MOVI: begin
						regEn = 1'b1;
						loadSel = SEL_IMM;
					end
					CMP: flagsEn = 1'b1;
					STOR: begin
						ramAddrSel = 1'b1;
						if (!ioStore) begin
							ramEn = 1'b1;
						end else if (portBusy) begin
							nextState = PORTWAIT;
						end else begin
							portLoad = 1'b1;
						end
					end
					BEQ, BLT: begin
						signedImm = 1'b1;
						pcSel = PC_DISP;
						pcEn = (opcode == BEQ) ? flags[FLAG_Z] : flags[FLAG_N];
					end
					HALT: nextState = HALTED;
					default: nextState = FETCH;
				endcase
			end
			MEMRD: begin
				ramAddrSel = 1'b1;
				nextState = MEMWAIT;
			end
			MEMWAIT: begin
				regEn = 1'b1;
				loadSel = SEL_RAM;
				nextState = FETCH;
			end
			PORTWAIT: begin
				// registers still hold the store operands
				if (!portBusy) begin
					portLoad = 1'b1;
					nextState = FETCH;
				end
			end
			HALTED: nextState = HALTED;
			default: nextState = IDLE;
		endcase
	end

endmodule

// File: verilog/portWriter.sv
module portWriter
	import isaPkg::*;
(
	input logic Clk,
	input logic arstN,
	input logic portLoad,
	input portAddr_t portAddrIn,
	input word_t portDataIn,
	output logic portBusy,
	output logic outValid,
	input logic outReady,
	output portAddr_t outAddr,
	output word_t outData
);

	// the FSM only loads while the holder is empty
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else if (portLoad) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;
		end
	end

	always_ff @(posedge Clk) begin
		if (portLoad) begin
			outAddr <= portAddrIn;
			outData <= portDataIn;
		end
	end

	assign portBusy = outValid;

endmodule

// File: verilog/cpu.sv
module cpu
	import isaPkg::*;
	import cpuCtrlPkg::*;
(
	input logic Clk,
	input logic arstN,
	input logic inValid,
	output logic inReady,
	input word_t inData,
	input logic inLast,
	output logic outValid,
	input logic outReady,
	output portAddr_t outAddr,
	output word_t outData,
	output logic halted
);

	logic loadWe;
	memAddr_t loadAddr;
	word_t loadData;
	logic start;
	logic regEn;
	logic ramEn;
	logic pcEn;
	logic immSel;
	logic signedImm;
	logic ramAddrSel;
	logic flagsEn;
	logic portLoad;
	logic portBusy;
	loadSel_t loadSel;
	pcSel_t pcSel;
	aluOp_t aluOp;
	regAddr_t rdestLoc;
	regAddr_t rsrcLoc;
	imm_t imm;
	word_t instr;
	flags_t flags;
	word_t rdestOut;
	word_t rsrcOut;
	word_t load;
	word_t extImm;
	word_t pc;
	memAddr_t coreAddr;

	programLoader loader_i (
		.Clk(Clk),
		.arstN(arstN),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.inLast(inLast),
		.loadWe(loadWe),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.start(start)
	);

	cpuRam ram_i (
		.Clk(Clk),
		.coreAddr(coreAddr),
		.coreData(rdestOut),
		.coreWe(ramEn),
		.coreQ(instr),
		.loadWe(loadWe),
		.loadAddr(loadAddr),
		.loadData(loadData)
	);

	regFile regs_i (
		.Clk(Clk),
		.arstN(arstN),
		.en(regEn),
		.rdestLoc(rdestLoc),
		.rsrcLoc(rsrcLoc),
		.load(load),
		.rdestOut(rdestOut),
		.rsrcOut(rsrcOut)
	);

	execUnit exec_i (
		.Clk(Clk),
		.arstN(arstN),
		.imm(imm),
		.signedImm(signedImm),
		.immSel(immSel),
		.aluOp(aluOp),
		.rdestOut(rdestOut),
		.rsrcOut(rsrcOut),
		.ramQ(instr),
		.loadSel(loadSel),
		.flagsEn(flagsEn),
		.load(load),
		.flags(flags),
		.extImm(extImm)
	);

	programCounter pc_i (
		.Clk(Clk),
		.arstN(arstN),
		.pcEn(pcEn),
		.pcSel(pcSel),
		.ramAddrSel(ramAddrSel),
		.extImm(extImm),
		.rsrcOut(rsrcOut),
		.pc(pc),
		.coreAddr(coreAddr)
	);

	controlFsm fsm_i (
		.Clk(Clk),
		.arstN(arstN),
		.start(start),
		.instr(instr),
		.flags(flags),
		.portBusy(portBusy),
		.storeAddr(rsrcOut[9:0]),
		.regEn(regEn),
		.ramEn(ramEn),
		.pcEn(pcEn),
		.immSel(immSel),
		.signedImm(signedImm),
		.ramAddrSel(ramAddrSel),
		.loadSel(loadSel),
		.pcSel(pcSel),
		.aluOp(aluOp),
		.rdestLoc(rdestLoc),
		.rsrcLoc(rsrcLoc),
		.imm(imm),
		.flagsEn(flagsEn),
		.portLoad(portLoad),
		.halted(halted)
	);

	// low address bits pick the word inside the I/O window
	portWriter port_i (
		.Clk(Clk),
		.arstN(arstN),
		.portLoad(portLoad),
		.portAddrIn(rsrcOut[3:0]),
		.portDataIn(rdestOut),
		.portBusy(portBusy),
		.outValid(outValid),
		.outReady(outReady),
		.outAddr(outAddr),
		.outData(outData)
	);

endmodule

// File: bench/cpuTb.sv
module cpuTb
	import isaPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALT_TIMEOUT = 3000;
	localparam int DRAIN_TIMEOUT = 300;
	localparam int QUIET_CYCLES = 20;

	logic Clk;
	logic arstN;
	logic inValid;
	logic inReady;
	word_t inData;
	logic inLast;
	logic outValid;
	logic outReady;
	portAddr_t outAddr;
	word_t outData;
	logic halted;

	word_t prog[$];
	portAddr_t expAddr[$];
	word_t expData[$];
	int gotCount;
	logic holding;
	portAddr_t heldAddr;
	word_t heldData;

	cpu dut_i (
		.Clk(Clk),
		.arstN(arstN),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.inLast(inLast),
		.outValid(outValid),
		.outReady(outReady),
		.outAddr(outAddr),
		.outData(outData),
		.halted(halted)
	);

	always begin
		#20 Clk = ~Clk;
	end

	task automatic reportMismatch(input string msg);
		$display("Fail at %0d ns: %s", $time, msg);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "run aborted");
	endtask

	// P lines hold program words, E lines hold expected port writes
	task automatic readVectors();
		int fd;
		int count;
		string line;
		logic [7:0] kind;
		logic [15:0] first;
		logic [15:0] second;
		fd = $fopen("bench/cpuTestdata.mem", "r");
		if (fd == 0) begin
			abortRun("could not open bench/cpuTestdata.mem");
		end
		while ($fgets(line, fd)) begin
			count = $sscanf(line, "%c %h %h", kind, first, second);
			if (kind == "P" && count >= 2) begin
				prog.push_back(first);
			end else if (kind == "E" && count == 3) begin
				expAddr.push_back(first[3:0]);
				expData.push_back(second);
			end
		end
		$fclose(fd);
		if (prog.size() == 0 || expData.size() == 0) begin
			abortRun("test data file holds no program or no expected writes");
		end
	endtask

	// one word per cycle, the loader never stalls before the last word
	task automatic sendWord(input word_t word, input logic last, input int index);
		assert (inReady)
			else reportMismatch($sformatf("inReady low before program word %0d", index));
		inValid = 1'b1;
		inData = word;
		inLast = last;
		@(posedge Clk);
		#2;
	endtask

	// random back-pressure, ready about one cycle in three
	always @(posedge Clk) begin
		#2;
		outReady = ($urandom % 3) == 0;
	end

	// outputs sampled at the falling edge, between two driving points
	always @(negedge Clk) begin
		if (!arstN) begin
			holding = 1'b0;
		end else begin
			if (holding) begin
				assert (outValid)
					else reportMismatch("outValid dropped before the word was taken");
				assert (outAddr == heldAddr && outData == heldData)
					else reportMismatch($sformatf(
						"port word changed while stalled: %0h %h, held %0h %h",
						outAddr, outData, heldAddr, heldData));
			end
			if (outValid && outReady) begin
				assert (gotCount < expData.size())
					else reportMismatch($sformatf("extra port write addr %0h data %h",
						outAddr, outData));
				assert (outAddr == expAddr[gotCount] && outData == expData[gotCount])
					else reportMismatch($sformatf("port write %0d is %0h %h, expected %0h %h",
						gotCount, outAddr, outData, expAddr[gotCount], expData[gotCount]));
				gotCount++;
				holding = 1'b0;
			end else if (outValid) begin
				holding = 1'b1;
				heldAddr = outAddr;
				heldData = outData;
			end
		end
	end

	initial begin
		int seedValue;
		int cycles;
		Clk = 1'b0;
		arstN = 1'b0;
		inValid = 1'b0;
		inData = '0;
		inLast = 1'b0;
		outReady = 1'b0;
		gotCount = 0;
		holding = 1'b0;
		seedValue = $urandom(51);
		readVectors();

		repeat (2) @(posedge Clk);
		#2;
		arstN = 1'b1;
		assert (inReady && !outValid && !halted)
			else reportMismatch("wrong output levels after reset");

		for (int i = 0; i < prog.size(); i++) begin
			sendWord(prog[i], i == prog.size() - 1, i);
		end
		inValid = 1'b0;
		inLast = 1'b0;
		inData = '0;
		assert (!inReady) else reportMismatch("inReady still high after the last word");

		cycles = 0;
		while (!halted) begin
			@(posedge Clk);
			#2;
			cycles++;
			if (cycles > HALT_TIMEOUT) begin
				abortRun("timeout: halted never rose");
			end
		end

		// the last port word may still sit in the holder
		cycles = 0;
		while (gotCount < expData.size()) begin
			@(posedge Clk);
			#2;
			cycles++;
			if (cycles > DRAIN_TIMEOUT) begin
				abortRun("timeout: expected port writes did not all arrive");
			end
		end

		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(posedge Clk);
			#2;
			assert (halted) else reportMismatch("halted dropped after the end of the run");
			assert (!outValid) else reportMismatch("port write after the end of the run");
		end

		$display("** PASS **");
		$finish;
	end

endmodule

// File: bench/cpuTestdata.mem
// P word: program word, loaded from RAM address zero up
// E offset data: expected port write, window offset and value, in order
P 8F3F // movi r15, 0x3f
P 9F04 // lshi r15, 4
P 7EF0 // mov r14, r15
P 1E05 // addi r14, 5
P 8134 // movi r1, 0x34
P 82A2 // movi r2, 0xa2
P 7310 // mov r3, r1
P 0320 // add r3, r2
P C3F0 // stor r3, [r15]
P 7420 // mov r4, r2
P 2410 // sub r4, r1
P C4E0 // stor r4, [r14]
P 7510 // mov r5, r1
P 4520 // and r5, r2
P C5F0 // stor r5, [r15]
P 7610 // mov r6, r1
P 5620 // or r6, r2
P C6E0 // stor r6, [r14]
P 7710 // mov r7, r1
P 6720 // xor r7, r2
P C7F0 // stor r7, [r15]
P 9708 // lshi r7, 8
P C7E0 // stor r7, [r14]
P 88C3 // movi r8, 0xc3
P C8F0 // stor r8, [r15]
P 89C0 // movi r9, 0xc0
P C790 // stor r7, [r9] to RAM
P BA90 // load r10, [r9]
P CAF0 // stor r10, [r15]
P 1AFF // addi r10, -1
P CAE0 // stor r10, [r14]
P 8B00 // movi r11, 0
P 8C04 // movi r12, 4
P 1B01 // loop: addi r11, 1
P CBF0 // stor r11, [r15]
P ABC0 // cmp r11, r12
P E0FC // blt loop
P D001 // beq skips the next store
P CCF0 // stor r12, [r15] never runs
P CBE0 // stor r11, [r14]
P F000 // halt
P CCF0 // past the halt
E 0 00D6 // add
E 5 006E // sub
E 0 0020 // and
E 5 00B6 // or
E 0 0096 // xor
E 5 9600 // lshi
E 0 00C3 // movi
E 0 9600 // through RAM
E 5 95FF // addi with negative immediate
E 0 0001 // loop count
E 0 0002
E 0 0003
E 0 0004
E 5 0004 // final count after beq

// File: cpu.f
verilog/isaPkg.sv
verilog/cpuCtrlPkg.sv
verilog/programLoader.sv
verilog/cpuRam.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/programCounter.sv
verilog/controlFsm.sv
verilog/portWriter.sv
verilog/cpu.sv
bench/cpuTb.sv

// File: run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f cpu.f --top-module cpuTb -o cpuSim
./obj_dir/cpuSim | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
